// File: cache.f
hdl/cache_pkg.sv
hdl/cache_way.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/cache_top.sv
testbench/cache_mem_model.sv
testbench/cache_tb.sv

// File: Bender.yml
package:
  name: cache

dependencies: {}

sources:
  - files:
      - hdl/cache_pkg.sv
      - hdl/cache_way.sv
      - hdl/cache_datapath.sv
      - hdl/cache_control.sv
      - hdl/cache_top.sv
  - target: test
    files:
      - testbench/cache_mem_model.sv
      - testbench/cache_tb.sv

// File: testbench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    import cache_pkg::*;

    localparam int          num_accesses   = 74;               // Sum over the tests below.
    localparam int          timeout_cycles = num_accesses * 20 + 200;
    localparam logic [15:0] fill_key       = 16'h5a3c;

    logic                  clk;
    logic                  arst_n;
    cpu_req_t              cpu_req;
    logic                  cpu_resp;
    logic [word_width-1:0] cpu_rdata;
    mem_req_t              mem_req;
    logic                  mem_resp;
    logic [line_width-1:0] mem_rdata;
    int                    wb_count;

    logic [15:0]          shadow [32768];                      // Current value of every word.
    logic [tag_width-1:0] tag_m [num_sets][2];
    logic [1:0]           valid_m [num_sets];
    logic [1:0]           dirty_m [num_sets];
    logic                 lru_m [num_sets];
    logic                 exp_hit;
    logic                 exp_wb;
    logic [15:0]          exp_wb_addr;
    logic [15:0]          exp_rdata;
    int err_cnt = 0;
    int test_cnt = 0;
    int access_cnt = 0;
    int exp_wb_cnt = 0;
    int cycle_cnt = 0;
    int mem_reads = 0;
    int mem_writes = 0;

    cache_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata)
    );

    cache_mem_model #(.fill_key(fill_key)) mem_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata),
        .wb_count  (wb_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic flag_error(input string msg);
        err_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    function automatic logic [line_width-1:0] shadow_line(input logic [15:0] addr);
        logic [line_width-1:0] line;
        for (int w = 0; w < 16; w++) begin
            line[w * 16 +: 16] = shadow[{addr[15:5], 4'b0000} + w];
        end
        return line;
    endfunction

    // One CPU access, with the expected hit, write-back and data taken from the model.
    task automatic access(input logic is_write, input logic [15:0] addr,
                          input logic [15:0] wdata, input logic [1:0] wmask);
        logic [index_width-1:0] idx;
        logic [tag_width-1:0]   tag;
        logic [15:0]            keep;
        logic                   way;
        idx = addr[7:5];
        tag = addr[15:8];
        @(negedge clk);
        exp_hit = 1'b0;
        way     = lru_m[idx];                                  // Victim unless a way hits.
        for (int w = 0; w < 2; w++) begin
            if (valid_m[idx][w] && tag_m[idx][w] == tag) begin
                exp_hit = 1'b1;
                way     = w[0];
            end
        end
        exp_wb      = !exp_hit && valid_m[idx][way] && dirty_m[idx][way];
        exp_wb_addr = {tag_m[idx][way], idx, 5'b00000};
        exp_rdata   = shadow[addr[15:1]];
        mem_reads   = 0;
        mem_writes  = 0;
        cpu_req     = '{read: !is_write, write: is_write, addr: addr, wdata: wdata, wmask: wmask};
        do begin
            @(posedge clk);
        end while (!cpu_resp);
        @(negedge clk);
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
        assert (mem_reads == int'(!exp_hit) && mem_writes == int'(exp_wb))
            else flag_error($sformatf("addr %h: %0d fills, %0d write-backs", addr,
                                      mem_reads, mem_writes));
        if (!exp_hit) begin
            tag_m[idx][way]   = tag;
            valid_m[idx][way] = 1'b1;
            dirty_m[idx][way] = 1'b0;
        end
        lru_m[idx] = !way;
        if (is_write) begin
            dirty_m[idx][way] = 1'b1;
            keep = {{8{!wmask[1]}}, {8{!wmask[0]}}};
            shadow[addr[15:1]] = (shadow[addr[15:1]] & keep) | (wdata & ~keep);
        end
        exp_wb_cnt += int'(exp_wb);
        access_cnt++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %-12s %s (%0d errors)", name,
                 (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol and data checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_exclusive_a: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_req.read && mem_req.write))
        else flag_error("memory read and write are high together");
    mem_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req.read || mem_req.write) && !mem_resp |=> $stable(mem_req))
        else flag_error("memory request changed before its response");
    fill_addr_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.read |-> mem_req.addr == {cpu_req.addr[15:5], 5'b00000})
        else flag_error($sformatf("fill address %h", mem_req.addr));
    wb_line_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.write |-> exp_wb && mem_req.addr == exp_wb_addr
                          && mem_req.wdata == shadow_line(exp_wb_addr))
        else flag_error($sformatf("write-back of %h, expected %h", mem_req.addr, exp_wb_addr));
    hit_same_cycle_a: assert property (@(posedge clk) disable iff (!arst_n)
        (cpu_req.read || cpu_req.write) && exp_hit
        |-> cpu_resp && !mem_req.read && !mem_req.write)
        else flag_error("resident line did not answer in the request cycle");
    miss_quiet_a: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(cpu_req.read || cpu_req.write) && !exp_hit |-> !cpu_resp)
        else flag_error("miss answered without a memory access");
    miss_start_a: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(cpu_req.read || cpu_req.write) && !exp_hit
        |=> mem_req.write == exp_wb && mem_req.read == !exp_wb)
        else flag_error("miss did not start the expected memory request");
    read_data_a: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_req.read && cpu_resp |-> cpu_rdata == exp_rdata)
        else flag_error($sformatf("read %h at %h, expected %h", cpu_rdata, cpu_req.addr,
                                  exp_rdata));

    // Memory traffic per access, and the watchdog.
    always @(posedge clk) begin
        cycle_cnt++;
        mem_reads  += int'(mem_resp && mem_req.read);
        mem_writes += int'(mem_resp && mem_req.write);
        if (cycle_cnt > timeout_cycles) begin
            $display("Timeout after %0d cycles, an access never completed.", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int          errs;
        logic [15:0] a;
        arst_n  = 1'b0;
        cpu_req = '0;
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        for (int i = 0; i < 32768; i++) begin
            shadow[i] = 16'(i << 1) ^ fill_key;
        end
        for (int s = 0; s < num_sets; s++) begin
            tag_m[s]   = '{default: '0};
            valid_m[s] = '0;
            dirty_m[s] = '0;
            lru_m[s]   = 1'b0;
        end
        repeat (4) @(negedge clk);
        errs = err_cnt;
        assert (!cpu_resp && !mem_req.read && !mem_req.write)
            else flag_error("outputs active in reset");
        arst_n = 1'b1;
        access(1'b0, 16'h0000, 16'h0000, 2'b00);                  // Cold cache misses.
        report_test("reset", errs);

        errs = err_cnt;
        for (int s = 0; s < 8; s++) begin
            access(1'b0, {8'h10, 3'(s), 4'(s), 1'b0}, 16'h0000, 2'b00);
            access(1'b0, {8'h10, 3'(s), 4'(15 - s), 1'b0}, 16'h0000, 2'b00);
        end
        report_test("read_fill", errs);

        errs = err_cnt;
        a = {8'h10, 3'd1, 4'd5, 1'b0};
        access(1'b1, a, 16'hbeef, 2'b01);
        access(1'b0, a, 16'h0000, 2'b00);
        access(1'b1, a, 16'h1234, 2'b10);
        access(1'b0, a, 16'h0000, 2'b00);
        access(1'b1, a, 16'hc0de, 2'b11);
        access(1'b0, a, 16'h0000, 2'b00);
        a = {8'h20, 3'd2, 4'd9, 1'b0};                            // Write-allocate.
        access(1'b1, a, 16'h7e57, 2'b11);
        access(1'b0, a, 16'h0000, 2'b00);
        report_test("write_merge", errs);

        errs = err_cnt;
        for (int s = 0; s < 8; s++) begin
            access(1'b0, {8'h10, 3'(s), 4'd7, 1'b0}, 16'h0000, 2'b00);
        end
        report_test("hit_repeat", errs);

        errs = err_cnt;
        for (int t = 0; t < 9; t++) begin
            access(t < 3, {8'h31 + 8'(t % 3), 3'd5, 4'(t % 3 * 3), 1'b0},
                   16'ha000 + 16'(t), 2'b11);
        end
        report_test("evict", errs);

        errs = err_cnt;
        for (int i = 0; i < 32; i++) begin
            a = {8'h40 + 8'((i * 5) % 3), (i % 2 == 1) ? 3'd3 : 3'd6, 4'(i * 7), 1'b0};
            access((i % 3) == 0, a, 16'(i * 4951), 2'(1 + i % 3));
        end
        report_test("mixed", errs);

        assert (wb_count == exp_wb_cnt)
            else flag_error($sformatf("memory saw %0d write-backs, expected %0d",
                                      wb_count, exp_wb_cnt));
        $display("%0d tests, %0d accesses, %0d write-backs, %0d errors",
                 test_cnt, access_cnt, wb_count, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/cache_mem_model.sv
`timescale 1ns/1ps

module cache_mem_model #(
    parameter logic [15:0] fill_key = 16'h5a3c
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  cache_pkg::mem_req_t              mem_req,
    output logic                             mem_resp,
    output logic [cache_pkg::line_width-1:0]  mem_rdata,
    output int                               wb_count
);

    import cache_pkg::*;

    localparam int          mem_words = 1 << (addr_width - 1);    // 64 KiB as 16-bit words.
    localparam logic [15:0] lfsr_taps = 16'hb400;

    logic [word_width-1:0] mem [mem_words];
    logic [15:0]           lfsr_q;
    logic [addr_width-1:0] wb_log [$];                             // Every write-back address.
    int                    wait_cnt;

    // Galois LFSR, one step per bit taken.
    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ lfsr_taps;
        end
        return out;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response engine, driven on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int   base;
        logic b0;
        logic b1;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = 16'(i << 1) ^ fill_key;                       // Byte address mixed with the key.
        end
        lfsr_q    = 16'd28683;
        mem_resp  = 1'b0;
        mem_rdata = '0;
        wb_count  = 0;
        wait_cnt  = 0;
        forever begin
            @(negedge clk);
            mem_resp = 1'b0;
            if (!arst_n || !(mem_req.read || mem_req.write)) begin
                wait_cnt = 0;
            end else if (wait_cnt == 0) begin
                b0       = lfsr_bit();
                b1       = lfsr_bit();
                wait_cnt = 1 + int'({b1, b0});                     // 1 to 4 cycles.
            end else begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    base = int'({mem_req.addr[addr_width-1:offset_width], 4'b0000});
                    if (mem_req.write) begin
                        for (int w = 0; w < 16; w++) begin
                            mem[base + w] = mem_req.wdata[w * 16 +: 16];
                        end
                        wb_log.push_back(mem_req.addr);
                        wb_count = wb_log.size();
                    end else begin
                        for (int w = 0; w < 16; w++) begin
                            mem_rdata[w * 16 +: 16] = mem[base + w];
                        end
                    end
                    mem_resp = 1'b1;                               // Single-cycle pulse.
                end
            end
        end
    end

endmodule

// File: hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  cache_pkg::cpu_req_t              cpu_req,
    output logic                             cpu_resp,
    output logic [cache_pkg::word_width-1:0]  cpu_rdata,
    output cache_pkg::mem_req_t              mem_req,
    input  logic                             mem_resp,
    input  logic [cache_pkg::line_width-1:0]  mem_rdata
);

    import cache_pkg::*;

    cache_status_t         status;
    cache_ctrl_t           ctrl;
    logic                  mem_read;
    logic                  mem_write;
    logic [addr_width-1:0] mem_addr;
    logic [line_width-1:0] mem_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller and datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    cache_control control_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .status    (status),
        .cpu_read  (cpu_req.read),
        .cpu_write (cpu_req.write),
        .mem_resp  (mem_resp),
        .ctrl      (ctrl),
        .cpu_resp  (cpu_resp),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    cache_datapath datapath_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .status    (status),
        .cpu_rdata (cpu_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // Strobes come from the controller, address and line from the datapath.
    assign mem_req = '{read: mem_read, write: mem_write, addr: mem_addr, wdata: mem_wdata};

endmodule

// File: hdl/cache_control.sv
`timescale 1ns/1ps

module cache_control (
    input  logic                    clk,
    input  logic                    arst_n,
    input  cache_pkg::cache_status_t status,
    input  logic                    cpu_read,
    input  logic                    cpu_write,
    input  logic                    mem_resp,
    output cache_pkg::cache_ctrl_t   ctrl,
    output logic                    cpu_resp,
    output logic                    mem_read,
    output logic                    mem_write
);

    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    logic         cpu_active;
    logic         hit_any;

    assign cpu_active = cpu_read | cpu_write;              // At most one is high.
    assign hit_any    = status.hit_0 | status.hit_1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctrl      = '0;
        cpu_resp  = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;

        unique case (state_q)
            state_idle_hit: begin
                if (cpu_active && hit_any) begin
                    ctrl.way_sel  = ~status.hit_0;         // Hit on way 1 when way 0 misses.
                    ctrl.lru_in   = status.hit_0;          // The other way becomes LRU.
                    ctrl.load_lru = 1'b1;
                    ctrl.load     = cpu_write;             // Word merge only for writes.
                    cpu_resp      = 1'b1;
                end
            end

            state_write_back: begin
                ctrl.way_sel        = status.lru_out;      // Victim line goes out.
                ctrl.tag_source_sel = 1'b0;                // Address of the victim.
                mem_write           = 1'b1;
            end

            state_read_in: begin
                ctrl.way_sel        = status.lru_out;
                ctrl.tag_source_sel = 1'b1;                // Address of the request.
                ctrl.load_all       = mem_resp;            // Line lands on the response edge.
                mem_read            = 1'b1;
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;

        unique case (state_q)
            state_idle_hit: begin
                if (cpu_active && !hit_any) begin
                    if (status.dirty_out) begin
                        state_d = state_write_back;       // Victim must be saved first.
                    end else begin
                        state_d = state_read_in;
                    end
                end
            end

            state_write_back: begin
                if (mem_resp) begin
                    state_d = state_read_in;
                end
            end

            state_read_in: begin
                if (mem_resp) begin
                    state_d = state_idle_hit;              // Request hits next cycle.
                end
            end

            default: begin
                state_d = state_idle_hit;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= state_idle_hit;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: hdl/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath (
    input  logic                             clk,
    input  logic                             arst_n,
    input  cache_pkg::cpu_req_t              cpu_req,
    input  cache_pkg::cache_ctrl_t           ctrl,
    input  logic [cache_pkg::line_width-1:0]  mem_rdata,
    output cache_pkg::cache_status_t         status,
    output logic [cache_pkg::word_width-1:0]  cpu_rdata,
    output logic [cache_pkg::addr_width-1:0]  mem_addr,
    output logic [cache_pkg::line_width-1:0]  mem_wdata
);

    import cache_pkg::*;

    logic [tag_width-1:0]                   cpu_tag;
    logic [index_width-1:0]                 index;
    logic [offset_width-byte_sel_width-1:0] word_idx;
    logic [line_width-1:0]                  line_0;
    logic [line_width-1:0]                  line_1;
    logic [line_width-1:0]                  sel_line;
    logic [line_width-1:0]                  write_line;
    logic [line_width-1:0]                  line_in;
    logic [tag_width-1:0]                   stored_tag_0;
    logic [tag_width-1:0]                   stored_tag_1;
    logic [tag_width-1:0]                   mem_tag;
    logic                                   hit_0;
    logic                                   hit_1;
    logic                                   dirty_0;
    logic                                   dirty_1;
    logic [num_sets-1:0]                    lru_q;

    // Address fields.
    assign cpu_tag  = cpu_req.addr[addr_width-1 -: tag_width];
    assign index    = cpu_req.addr[offset_width +: index_width];
    assign word_idx = cpu_req.addr[offset_width-1:byte_sel_width];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write merge and fill routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sel_line = ctrl.way_sel ? line_1 : line_0;

    always_comb begin
        write_line = sel_line;
        for (int b = 0; b < word_bytes; b++) begin
            if (cpu_req.wmask[b]) begin
                write_line[(word_idx * word_bytes + b) * 8 +: 8] = cpu_req.wdata[b * 8 +: 8];
            end
        end
    end

    assign line_in = ctrl.load_all ? mem_rdata : write_line;   // Fill wins over a word write.

    cache_way way0_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (index),
        .tag        (cpu_tag),
        .load       (ctrl.load && !ctrl.way_sel),
        .load_all   (ctrl.load_all && !ctrl.way_sel),
        .line_in    (line_in),
        .hit        (hit_0),
        .dirty      (dirty_0),
        .stored_tag (stored_tag_0),
        .line_out   (line_0)
    );

    cache_way way1_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (index),
        .tag        (cpu_tag),
        .load       (ctrl.load && ctrl.way_sel),
        .load_all   (ctrl.load_all && ctrl.way_sel),
        .line_in    (line_in),
        .hit        (hit_1),
        .dirty      (dirty_1),
        .stored_tag (stored_tag_1),
        .line_out   (line_1)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Replacement and outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_q <= '0;                                   // Way 0 is replaced first.
        end else if (ctrl.load_lru) begin
            lru_q[index] <= ctrl.lru_in;
        end
    end

    always_comb begin
        status.hit_0     = hit_0;
        status.hit_1     = hit_1;
        status.lru_out   = lru_q[index];
        status.dirty_out = lru_q[index] ? dirty_1 : dirty_0;
    end

    assign cpu_rdata = sel_line[word_idx * word_width +: word_width];
    assign mem_wdata = sel_line;                           // Victim line on write-back.
    assign mem_tag   = ctrl.tag_source_sel ? cpu_tag
                     : (ctrl.way_sel ? stored_tag_1 : stored_tag_0);
    assign mem_addr  = {mem_tag, index, {offset_width{1'b0}}};

endmodule

// File: hdl/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [cache_pkg::index_width-1:0] index,
    input  logic [cache_pkg::tag_width-1:0]   tag,
    input  logic                             load,
    input  logic                             load_all,
    input  logic [cache_pkg::line_width-1:0]  line_in,
    output logic                             hit,
    output logic                             dirty,
    output logic [cache_pkg::tag_width-1:0]   stored_tag,
    output logic [cache_pkg::line_width-1:0]  line_out
);

    import cache_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [tag_width-1:0]  tag_q  [num_sets];
    logic [line_width-1:0] line_q [num_sets];
    logic [num_sets-1:0]   valid_q;
    logic [num_sets-1:0]   dirty_q;

    // Data and tags.
    always_ff @(posedge clk) begin
        if (load || load_all) begin
            line_q[index] <= line_in;                      // Merged word or a full fill.
        end
        if (load_all) begin
            tag_q[index] <= tag;
        end
    end

    // Line state bits.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (load_all) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;                        // Fresh from memory.
        end else if (load) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign stored_tag = tag_q[index];
    assign line_out   = line_q[index];
    assign dirty      = dirty_q[index];
    assign hit        = valid_q[index] && (tag_q[index] == tag);   // Read in the same cycle.

endmodule

// File: hdl/cache_pkg.sv
package cache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int addr_width     = 16;                     // Byte address.
    localparam int word_width     = 16;                     // CPU word.
    localparam int word_bytes     = word_width / 8;         // Bytes per CPU word.
    localparam int byte_sel_width = $clog2(word_bytes);     // Byte-in-word address bits.
    localparam int line_bytes     = 32;
    localparam int line_width     = line_bytes * 8;         // One line moved per memory access.
    localparam int offset_width   = $clog2(line_bytes);     // 5 bits.
    localparam int index_width    = 3;
    localparam int num_sets       = 1 << index_width;       // 8 sets.
    localparam int tag_width      = addr_width - index_width - offset_width;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port structs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        logic [word_bytes-1:0] wmask;                       // Bit 0 is the low byte.
    } cpu_req_t;

    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [addr_width-1:0] addr;                        // Always line aligned.
        logic [line_width-1:0] wdata;
    } mem_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller and datapath link
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic hit_0;
        logic hit_1;
        logic dirty_out;                                    // Dirty bit of the LRU way.
        logic lru_out;                                      // Way to replace next.
    } cache_status_t;

    typedef struct packed {
        logic way_sel;                                      // Way read or loaded.
        logic tag_source_sel;                               // 0 stored tag, 1 CPU tag.
        logic load;                                         // Word write on a hit.
        logic load_all;                                     // Line fill from memory.
        logic load_lru;
        logic lru_in;
    } cache_ctrl_t;

    typedef enum logic [1:0] {
        state_idle_hit,
        state_write_back,
        state_read_in
    } cache_state_e;

endpackage
